// ==== tb.f ====
logic/daq_pkg.sv
logic/capture_control.sv
logic/record_fifo.sv
logic/sample_discriminator.sv
logic/stream_merger.sv
logic/daq_capture.sv
bench/clock_gen.sv
bench/daq_capture_tb.sv

// ==== bench/daq_capture_tb.sv ====
`timescale 1ns/1ps
/* testbench for daq_capture; a per-channel hysteresis model feeds concurrent assertions
   the round-robin check looks at the merger grant inside the DUT */
module daq_capture_tb import daq_pkg::*; ();

  localparam int timeout_cycles = 4000;

  logic ps_clk;
  logic reset;
  cfg_word_t cfg;
  logic cfg_valid;
  logic cfg_ready;
  sample_t adc_sample [num_channels];
  logic [num_channels-1:0] adc_valid;
  logic [num_channels-1:0] adc_ready;
  dma_word_t dma;
  logic dma_valid;
  logic dma_ready;

  // reference model state
  sample_record_t exp_q [num_channels][$];
  sample_record_t exp_head [num_channels];
  logic [num_channels-1:0] exp_avail;
  logic model_capturing;
  logic model_saving [num_channels];
  thresh_t model_thresh [num_channels];
  logic [timestamp_width-1:0] cycle_count;
  logic last_grant;
  logic adc_stalled;
  int end_count;
  int error_count;
  int tests_passed;
  int tests_failed;
  int unsigned run_cycles = 0;
  sample_t run_seq [$] = '{50, 150, 80, 30, 10, 120, 101, 100, 19, 200, 20, -5};

  clock_gen clock_gen_inst (.ps_clk(ps_clk), .reset(reset));

  daq_capture daq_capture_inst (.*);

  always @(posedge ps_clk) begin : model
    sample_record_t r;
    logic keep;
    if (reset) begin
      cycle_count = '0;
      model_capturing = 1'b0;
      last_grant = 1'b1;
      for (int ch = 0; ch < num_channels; ch++) begin
        model_saving[ch] = 1'b0;
        model_thresh[ch] = '{high: sample_max, low: sample_max};
        exp_q[ch].delete();
      end
    end else begin
      for (int ch = 0; ch < num_channels; ch++) begin
        if (adc_valid[ch] && !adc_ready[ch]) begin
          adc_stalled = 1'b1;
        end
        if (adc_valid[ch] && adc_ready[ch]) begin
          // a run opens strictly above high and holds while at or above low
          if (!model_capturing) begin
            keep = 1'b0;
          end else if (model_saving[ch]) begin
            keep = adc_sample[ch] >= model_thresh[ch].low;
          end else begin
            keep = adc_sample[ch] > model_thresh[ch].high;
          end
          if (keep) begin
            r = '{channel: 1'(ch), first: !model_saving[ch], sample: adc_sample[ch],
                  timestamp: cycle_count};
            exp_q[ch].push_back(r);
          end
          model_saving[ch] = keep;
        end
      end
      if (dma_valid && dma_ready) begin
        if (dma.kind == rec_end) begin
          end_count++;
        end else if (exp_q[dma.rec.channel].size() > 0) begin
          void'(exp_q[dma.rec.channel].pop_front());
        end
      end
      if (cfg_valid && cfg_ready) begin
        case (cfg.op)
          op_set_thresh: model_thresh[cfg.channel] = cfg.thresh;
          op_start: model_capturing = 1'b1;
          op_stop: model_capturing = 1'b0;
          default: ;
        endcase
      end
      if (daq_capture_inst.rec_ready[0]) begin
        last_grant = 1'b0;
      end else if (daq_capture_inst.rec_ready[1]) begin
        last_grant = 1'b1;
      end
      cycle_count = cycle_count + 1'b1;
      for (int ch = 0; ch < num_channels; ch++) begin
        exp_avail[ch] = exp_q[ch].size() > 0;
        if (exp_avail[ch]) begin
          exp_head[ch] = exp_q[ch][0];
        end
      end
    end
  end

  a_record_expected: assert property (@(posedge ps_clk) disable iff (reset)
    dma_valid && dma_ready && dma.kind == rec_sample |-> exp_avail[dma.rec.channel])
    else begin
      error_count++;
      $display("%0t: record arrived on channel %0d with none expected", $time,
        $sampled(dma.rec.channel));
    end

  a_record_value: assert property (@(posedge ps_clk) disable iff (reset)
    dma_valid && dma_ready && dma.kind == rec_sample && exp_avail[dma.rec.channel]
    |-> dma.rec == exp_head[dma.rec.channel])
    else begin
      error_count++;
      $display("[ERROR] %0t dma.rec expected %h actual %h", $time,
        $sampled(exp_head[dma.rec.channel]), $sampled(dma.rec));
    end

  a_dma_held: assert property (@(posedge ps_clk) disable iff (reset)
    dma_valid && !dma_ready |=> dma_valid && $stable(dma))
    else begin
      error_count++;
      $display("%0t: dma word changed or dropped while stalled", $time);
    end

  // end word closes the stream, nothing may follow it from the queues
  a_end_word: assert property (@(posedge ps_clk) disable iff (reset)
    dma_valid && (dma.last || dma.kind == rec_end)
    |-> dma.last && dma.kind == rec_end && exp_avail == '0)
    else begin
      error_count++;
      $display("%0t: end word malformed or sent before all records", $time);
    end

  a_stop_blocks_cfg: assert property (@(posedge ps_clk) disable iff (reset)
    cfg_valid && cfg_ready && cfg.op == op_stop |=> !cfg_ready)
    else begin
      error_count++;
      $display("%0t: cfg_ready stayed high after stop", $time);
    end

  a_round_robin: assert property (@(posedge ps_clk) disable iff (reset)
    (|daq_capture_inst.rec_ready) && (&daq_capture_inst.rec_valid)
    |-> !daq_capture_inst.rec_ready[last_grant])
    else begin
      error_count++;
      $display("%0t: channel %0d granted twice while both queues held data", $time,
        $sampled(last_grant));
    end

  always @(posedge ps_clk) begin
    run_cycles++;
    if (run_cycles >= timeout_cycles) begin
      $display("timeout: run still busy after %0d cycles", run_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // all tasks start and end on a falling edge
  task automatic push_sample(input int ch, input sample_t value);
    logic accepted;
    adc_sample[ch] = value;
    adc_valid[ch] = 1'b1;
    do begin
      accepted = adc_ready[ch];
      @(negedge ps_clk);
    end while (!accepted);
    adc_valid[ch] = 1'b0;
  endtask

  task automatic push_list(input int ch);
    foreach (run_seq[i]) begin
      push_sample(ch, run_seq[i]);
    end
  endtask

  task automatic stream_samples(input int ch, input int count, input int gap_pct,
                                input int lo, input int hi);
    repeat (count) begin
      while ($urandom_range(99) < gap_pct) begin
        @(negedge ps_clk);
      end
      push_sample(ch, sample_t'(lo + int'($urandom_range(hi - lo))));
    end
  endtask

  task automatic send_cfg(input cfg_op_e opcode, input logic ch, input int high, input int low);
    logic accepted;
    cfg = '{op: opcode, channel: ch, thresh: '{high: sample_t'(high), low: sample_t'(low)}};
    cfg_valid = 1'b1;
    do begin
      accepted = cfg_ready;
      @(negedge ps_clk);
    end while (!accepted);
    cfg_valid = 1'b0;
  endtask

  task automatic random_ready(input int cycles, input int pct);
    repeat (cycles) begin
      dma_ready = $urandom_range(99) < pct;
      @(negedge ps_clk);
    end
    dma_ready = 1'b1;
  endtask

  task automatic stall_pattern(input int rounds, input int low_cycles, input int high_cycles);
    repeat (rounds) begin
      dma_ready = 1'b0;
      repeat (low_cycles) @(negedge ps_clk);
      dma_ready = 1'b1;
      repeat (high_cycles) @(negedge ps_clk);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    while (exp_avail != '0 || dma_valid) begin
      @(negedge ps_clk);
    end
    repeat (2) @(negedge ps_clk);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    int base;
    void'($urandom(32107));
    cfg = '0;
    cfg_valid = 1'b0;
    adc_valid = '0;
    adc_sample[0] = '0;
    adc_sample[1] = '0;
    dma_ready = 1'b1;
    adc_stalled = 1'b0;
    end_count = 0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (!reset);
    @(negedge ps_clk);

    // samples before start must vanish
    base = error_count;
    send_cfg(op_set_thresh, 0, 100, 20);
    send_cfg(op_set_thresh, 1, 200, -50);
    push_sample(0, 500);
    push_sample(0, 300);
    send_cfg(op_start, 0, 0, 0);
    push_list(0);
    report_test("threshold keeping", base);

    base = error_count;
    stream_samples(1, 25, 50, -200, 400);
    report_test("timestamps", base);

    base = error_count;
    fork
      stream_samples(0, 50, 30, -100, 300);
      stream_samples(1, 50, 30, -200, 400);
      random_ready(300, 70);
    join
    report_test("two-channel merge", base);

    // keep everything so the queues fill while stalled
    base = error_count;
    adc_stalled = 1'b0;
    send_cfg(op_set_thresh, 0, -30000, -30000);
    send_cfg(op_set_thresh, 1, -30000, -30000);
    fork
      stream_samples(0, 30, 0, -20000, 20000);
      stream_samples(1, 30, 0, -20000, 20000);
      stall_pattern(8, 40, 4);
    join
    assert (adc_stalled) else begin
      error_count++;
      $display("adc_ready never dropped under back-pressure");
    end
    report_test("back-pressure", base);

    base = error_count;
    end_count = 0;
    dma_ready = 1'b0;
    fork
      stream_samples(0, 3, 0, -20000, 20000);
      stream_samples(1, 3, 0, -20000, 20000);
    join
    send_cfg(op_stop, 0, 0, 0);
    repeat (10) @(negedge ps_clk);
    assert (!cfg_ready) else begin
      error_count++;
      $display("cfg_ready returned before the stream was closed");
    end
    dma_ready = 1'b1;
    while (!cfg_ready) begin
      @(negedge ps_clk);
    end
    repeat (4) @(negedge ps_clk);
    assert (end_count == 1 && exp_avail == '0) else begin
      error_count++;
      $display("expected one end word after all records, saw %0d", end_count);
    end
    report_test("stop and drain", base);

    base = error_count;
    send_cfg(op_set_thresh, 0, 100, 20);
    send_cfg(op_set_thresh, 1, 100, 20);
    send_cfg(op_start, 0, 0, 0);
    fork
      push_list(0);
      push_list(1);
    join
    send_cfg(op_set_thresh, 1, 140, 90);
    fork
      push_list(0);
      push_list(1);
    join
    report_test("threshold update", base);

    $display("tests passed %0d, tests with errors %0d, errors %0d", tests_passed,
      tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
/* 20 ns ps_clk; reset high for the first 3 rising edges, released on a falling edge */
module clock_gen (
  output logic ps_clk,
  output logic reset
);

  initial begin
    ps_clk = 1'b0;
    forever begin
      #10 ps_clk = ~ps_clk;
    end
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge ps_clk);
    @(negedge ps_clk);
    reset = 1'b0;
  end

endmodule

// ==== logic/daq_capture.sv ====
`timescale 1ns/1ps
/* two-channel capture top, single clock; all handshakes are valid/ready
   one discriminator per channel feeds the merger, control supplies commands and time */
module daq_capture import daq_pkg::*; (
  input  logic                    ps_clk,
  input  logic                    reset,
  input  cfg_word_t               cfg,
  input  logic                    cfg_valid,
  output logic                    cfg_ready,
  input  sample_t                 adc_sample [num_channels],
  input  logic [num_channels-1:0] adc_valid,
  output logic [num_channels-1:0] adc_ready,
  output dma_word_t               dma,
  output logic                    dma_valid,
  input  logic                    dma_ready
);

  logic capturing;
  logic drain_request;
  logic end_sent;
  thresh_t thresh [num_channels];
  logic [timestamp_width-1:0] timestamp;
  sample_record_t rec [num_channels];
  logic [num_channels-1:0] rec_valid;
  logic [num_channels-1:0] rec_ready;
  logic [num_channels-1:0] idle;

  capture_control capture_control_inst (
    .ps_clk        (ps_clk),
    .reset         (reset),
    .cfg           (cfg),
    .cfg_valid     (cfg_valid),
    .cfg_ready     (cfg_ready),
    .end_sent      (end_sent),
    .capturing     (capturing),
    .drain_request (drain_request),
    .thresh        (thresh),
    .timestamp     (timestamp)
  );

  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    sample_discriminator sample_discriminator_inst (
      .ps_clk     (ps_clk),
      .reset      (reset),
      .channel_id (1'(ch)),
      .adc_sample (adc_sample[ch]),
      .adc_valid  (adc_valid[ch]),
      .adc_ready  (adc_ready[ch]),
      .capturing  (capturing),
      .thresh     (thresh[ch]),
      .timestamp  (timestamp),
      .rec        (rec[ch]),
      .rec_valid  (rec_valid[ch]),
      .rec_ready  (rec_ready[ch]),
      .idle       (idle[ch])
    );
  end

  stream_merger stream_merger_inst (
    .ps_clk        (ps_clk),
    .reset         (reset),
    .rec_in        (rec),
    .rec_valid     (rec_valid),
    .rec_ready     (rec_ready),
    .idle          (idle),
    .drain_request (drain_request),
    .dma           (dma),
    .dma_valid     (dma_valid),
    .dma_ready     (dma_ready),
    .end_sent      (end_sent)
  );

endmodule

// ==== logic/stream_merger.sv ====
`timescale 1ns/1ps
/* round-robin merge of two record queues into one registered dma stream
   one end word with last closes the stream once a drain finds all channels idle */
module stream_merger import daq_pkg::*; (
  input  logic                    ps_clk,
  input  logic                    reset,
  input  sample_record_t          rec_in [num_channels],
  input  logic [num_channels-1:0] rec_valid,
  output logic [num_channels-1:0] rec_ready,
  input  logic [num_channels-1:0] idle,
  input  logic                    drain_request,
  output dma_word_t               dma,
  output logic                    dma_valid,
  input  logic                    dma_ready,
  output logic                    end_sent
);

  logic load_en;
  logic prio;
  logic grant_valid;
  logic grant_ch;
  logic end_done;
  logic send_end;

  // output register is empty or being emptied this cycle
  assign load_en = !dma_valid || dma_ready;

  // prio names the channel served first
  always_comb begin
    grant_valid = 1'b0;
    grant_ch = prio;
    if (rec_valid[prio]) begin
      grant_valid = 1'b1;
      grant_ch = prio;
    end else if (rec_valid[~prio]) begin
      grant_valid = 1'b1;
      grant_ch = ~prio;
    end
  end

  always_comb begin
    rec_ready = '0;
    if (load_en && grant_valid) begin
      rec_ready[grant_ch] = 1'b1;
    end
  end

  // all idle means no queue can raise rec_valid, so this never meets a grant
  assign send_end = load_en && drain_request && !end_done && (&idle);

  always_ff @(posedge ps_clk) begin
    if (reset) begin
      dma_valid <= 1'b0;
      prio <= 1'b0;
      end_done <= 1'b0;
      end_sent <= 1'b0;
    end else begin
      end_sent <= dma_valid && dma_ready && dma.last;
      if (!drain_request) begin
        end_done <= 1'b0;
      end else if (send_end) begin
        end_done <= 1'b1;
      end
      if (load_en) begin
        dma_valid <= grant_valid || send_end;
      end
      if (load_en && grant_valid) begin
        prio <= ~grant_ch;
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (load_en && grant_valid) begin
      dma <= '{kind: rec_sample, last: 1'b0, rec: rec_in[grant_ch]};
    end else if (send_end) begin
      dma <= '{kind: rec_end, last: 1'b1, rec: '0};
    end
  end

  // stalled word must not change under the consumer
  a_dma_stable: assert property (@(posedge ps_clk) disable iff (reset)
    dma_valid && !dma_ready |=> dma_valid && $stable(dma));

endmodule

// ==== logic/sample_discriminator.sv ====
`timescale 1ns/1ps
/* hysteresis keep/drop for one channel; kept samples pass one register, then the queue
   a run starts above high and ends on the first sample below low, which is dropped */
module sample_discriminator import daq_pkg::*; (
  input  logic                       ps_clk,
  input  logic                       reset,
  input  logic                       channel_id,
  input  sample_t                    adc_sample,
  input  logic                       adc_valid,
  output logic                       adc_ready,
  input  logic                       capturing,
  input  thresh_t                    thresh,
  input  logic [timestamp_width-1:0] timestamp,
  output sample_record_t             rec,
  output logic                       rec_valid,
  input  logic                       rec_ready,
  output logic                       idle
);

  logic saving;
  logic start_run;
  logic keep;
  logic adc_fire;
  sample_record_t pipe_rec;
  logic pipe_valid;
  logic pipe_ready;

  // queue not full; the pipe register always empties on an accepting edge
  assign adc_ready = pipe_ready;
  assign adc_fire = adc_valid && adc_ready;

  always_comb begin
    start_run = !saving && (adc_sample > thresh.high);
    keep = capturing && (start_run || (saving && adc_sample >= thresh.low));
  end

  // saving follows the keep decision of every accepted sample
  always_ff @(posedge ps_clk) begin
    if (reset) begin
      saving <= 1'b0;
      pipe_valid <= 1'b0;
    end else begin
      if (pipe_valid && pipe_ready) begin
        pipe_valid <= 1'b0;
      end
      if (adc_fire) begin
        saving <= keep;
        if (keep) begin
          pipe_valid <= 1'b1;
        end
      end
    end
  end

  // tag with the counter value of the transfer cycle
  always_ff @(posedge ps_clk) begin
    if (adc_fire && keep) begin
      pipe_rec <= '{
        channel: channel_id,
        first: start_run,
        sample: adc_sample,
        timestamp: timestamp
      };
    end
  end

  record_fifo record_fifo_inst (
    .ps_clk   (ps_clk),
    .reset    (reset),
    .wr_data  (pipe_rec),
    .wr_valid (pipe_valid),
    .wr_ready (pipe_ready),
    .rd_data  (rec),
    .rd_valid (rec_valid),
    .rd_ready (rec_ready)
  );

  // nothing in flight on this channel
  assign idle = !pipe_valid && !rec_valid;

endmodule

// ==== logic/record_fifo.sv ====
`timescale 1ns/1ps
/* fifo_depth-entry queue of sample records, read data shown combinationally
   pointers wrap by overflow, so the depth must be a power of two */
module record_fifo import daq_pkg::*; (
  input  logic           ps_clk,
  input  logic           reset,
  input  sample_record_t wr_data,
  input  logic           wr_valid,
  output logic           wr_ready,
  output sample_record_t rd_data,
  output logic           rd_valid,
  input  logic           rd_ready
);

  sample_record_t mem [fifo_depth];
  logic [fifo_addr_width-1:0] wr_ptr;
  logic [fifo_addr_width-1:0] rd_ptr;
  logic [fifo_addr_width:0] count;
  logic wr_fire;
  logic rd_fire;

  assign wr_ready = count != (fifo_addr_width+1)'(fifo_depth);
  assign rd_valid = count != '0;
  assign rd_data = mem[rd_ptr];
  assign wr_fire = wr_valid && wr_ready;
  assign rd_fire = rd_valid && rd_ready;

  always_ff @(posedge ps_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge ps_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // a full queue leaves the writer holding its record until space opens
  a_no_write_when_full: assert property (@(posedge ps_clk) disable iff (reset)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

  // the reader only pops a queue that holds something
  a_no_read_when_empty: assert property (@(posedge ps_clk) disable iff (reset)
    rd_ready |-> rd_valid);

endmodule

// ==== logic/capture_control.sv ====
`timescale 1ns/1ps
/* command decoder, per-channel thresholds and the free-running timestamp
   thresholds power up at sample_max, so nothing is kept before op_set_thresh
   commands are refused while a drain is pending */
module capture_control import daq_pkg::*; (
  input  logic                       ps_clk,
  input  logic                       reset,
  input  cfg_word_t                  cfg,
  input  logic                       cfg_valid,
  output logic                       cfg_ready,
  input  logic                       end_sent,
  output logic                       capturing,
  output logic                       drain_request,
  output thresh_t                    thresh [num_channels],
  output logic [timestamp_width-1:0] timestamp
);

  logic cfg_fire;

  // ready drops the cycle after stop and returns the cycle after end_sent
  assign cfg_ready = !drain_request;
  assign cfg_fire = cfg_valid && cfg_ready;

  always_ff @(posedge ps_clk) begin
    if (reset) begin
      capturing <= 1'b0;
      drain_request <= 1'b0;
    end else begin
      if (end_sent) begin
        drain_request <= 1'b0;
      end
      if (cfg_fire) begin
        case (cfg.op)
          op_start: begin
            capturing <= 1'b1;
          end
          op_stop: begin
            capturing <= 1'b0;
            drain_request <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // per-channel hysteresis levels
  always_ff @(posedge ps_clk) begin
    if (reset) begin
      for (int i = 0; i < num_channels; i++) begin
        thresh[i] <= '{high: sample_max, low: sample_max};
      end
    end else if (cfg_fire && cfg.op == op_set_thresh) begin
      thresh[cfg.channel] <= cfg.thresh;
    end
  end

  // cycle counter, zero in the first cycle after reset
  always_ff @(posedge ps_clk) begin
    if (reset) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // a restart must wait until the merger has closed the stream
  a_no_start_while_draining: assert property (@(posedge ps_clk) disable iff (reset)
    drain_request |=> !capturing);

endmodule

// ==== logic/daq_pkg.sv ====
/* shared sizes, enums and record layouts for the two-channel capture path
   fifo_depth must be a power of two; the merger assumes exactly two channels */
package daq_pkg;

  localparam int num_channels = 2;
  localparam int sample_width = 16;
  localparam int timestamp_width = 32;
  localparam int fifo_depth = 4;
  localparam int fifo_addr_width = $clog2(fifo_depth);

  // configuration opcodes
  typedef enum logic [1:0] {
    op_set_thresh = 2'd0,
    op_start      = 2'd1,
    op_stop       = 2'd2
  } cfg_op_e;

  // kind of word on the dma stream
  typedef enum logic {
    rec_sample = 1'b0,
    rec_end    = 1'b1
  } record_kind_e;

  typedef logic signed [sample_width-1:0] sample_t;

  // largest positive sample, used as the power-up threshold
  localparam sample_t sample_max = {1'b0, {(sample_width-1){1'b1}}};

  typedef struct packed {
    sample_t high;
    sample_t low;
  } thresh_t;

  typedef struct packed {
    cfg_op_e op;
    logic    channel;
    thresh_t thresh;
  } cfg_word_t;

  typedef struct packed {
    logic                       channel;
    logic                       first;
    sample_t                    sample;
    logic [timestamp_width-1:0] timestamp;
  } sample_record_t;

  typedef struct packed {
    record_kind_e   kind;
    logic           last;
    sample_record_t rec;
  } dma_word_t;

endpackage
